// ==== msx_glue.f ====
+incdir+src
src/msx_glue_pkg.sv
src/osd_status_decode.sv
src/hdmi_crop_select.sv
src/sd_card_select.sv
src/ddr3_read_arbiter.sv
src/msx_glue_top.sv
test/tb_msx_glue.sv

// ==== src/ddr3_read_arbiter.sv ====
// DDR3 read arbiter
// Shares one byte read port between the ROM pack loader and the
// cassette player, four-phase req/ack on each client side
`timescale 1ns/1ps
`include "msx_glue_params.svh"

module ddr3_read_arbiter (
   input  logic                        clk21m,
   input  logic                        arst_n,
   input  logic                        loader_req,
   input  logic [`MSX_DDR_ADDR_W-1:0]  loader_addr,
   output logic                        loader_ack,
   output logic [`MSX_DDR_DATA_W-1:0]  loader_data,
   input  logic                        tape_req,
   input  logic [`MSX_DDR_ADDR_W-1:0]  tape_addr,
   output logic                        tape_ack,
   output logic [`MSX_DDR_DATA_W-1:0]  tape_data,
   input  logic                        ddr3_ready,
   input  logic [`MSX_DDR_DATA_W-1:0]  ddr3_dout,
   output logic                        ddr3_rd,
   output logic [`MSX_DDR_ADDR_W-1:0]  ddr3_addr
);

   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_ISSUE = 2'd1;
   localparam logic [1:0] ST_WAIT  = 2'd2;
   localparam logic [1:0] ST_ACK   = 2'd3;

   logic [1:0]                 state;
   msx_glue_pkg::ddr_client_t  grant;
   logic                       granted_req;

   assign granted_req = (grant == msx_glue_pkg::LOADER) ? loader_req : tape_req;

   // Address follows the winner until the read is issued
   always_ff @(posedge clk21m) begin
      if (state == ST_IDLE) begin
         ddr3_addr <= loader_req ? loader_addr : tape_addr;
      end
   end

   // ====================
   // Request FSM
   // ====================
   always_ff @(posedge clk21m or negedge arst_n) begin
      if (!arst_n) begin
         state       <= ST_IDLE;
         grant       <= msx_glue_pkg::LOADER;
         ddr3_rd     <= 1'b0;
         loader_ack  <= 1'b0;
         tape_ack    <= 1'b0;
         loader_data <= '0;
         tape_data   <= '0;
      end else begin
         ddr3_rd <= 1'b0;
         case (state)
            ST_IDLE: begin
               // Loader wins a tie
               if (loader_req || tape_req) begin
                  grant   <= loader_req ? msx_glue_pkg::LOADER : msx_glue_pkg::TAPE;
                  ddr3_rd <= 1'b1;
                  state   <= ST_ISSUE;
               end
            end
            ST_ISSUE, ST_WAIT: begin
               if (ddr3_ready) begin
                  if (grant == msx_glue_pkg::LOADER) begin
                     loader_data <= ddr3_dout;
                     loader_ack  <= 1'b1;
                  end else begin
                     tape_data <= ddr3_dout;
                     tape_ack  <= 1'b1;
                  end
                  state <= ST_ACK;
               end else begin
                  state <= ST_WAIT;
               end
            end
            ST_ACK: begin
               // Hold ack until the client drops its request
               if (!granted_req) begin
                  loader_ack <= 1'b0;
                  tape_ack   <= 1'b0;
                  state      <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   a_one_ack: assert property (
      @(posedge clk21m) disable iff (!arst_n) !(loader_ack && tape_ack)
   );

   a_rd_pulse: assert property (
      @(posedge clk21m) disable iff (!arst_n) ddr3_rd |=> !ddr3_rd
   );

endmodule

// ==== src/hdmi_crop_select.sv ====
// HDMI crop and aspect select
// Picks the vertical crop from the output resolution and forms the
// aspect numerators for the video scaler
`timescale 1ns/1ps
`include "msx_glue_params.svh"

module hdmi_crop_select (
   input  logic                         clk21m,
   input  logic                         arst_n,
   input  logic [`MSX_HDMI_DIM_W-1:0]   hdmi_width,
   input  logic [`MSX_HDMI_DIM_W-1:0]   hdmi_height,
   input  logic                         scandoubler,
   input  logic                         vcrop_en,
   input  msx_glue_pkg::aspect_t        aspect,
   output logic [`MSX_VCROP_W-1:0]      crop_size,
   output logic [`MSX_AR_W-1:0]         arx,
   output logic [`MSX_AR_W-1:0]         ary
);

   localparam int AR_W = `MSX_AR_W;

   logic [`MSX_VCROP_W-1:0]    vcrop;
   logic                       wide;
   logic [`MSX_HDMI_DIM_W:0]   min_wide_w;

   // Height plus half height, one extra bit so it cannot wrap
   assign min_wide_w = {1'b0, hdmi_height} + {2'b00, hdmi_height[`MSX_HDMI_DIM_W-1:1]};

   // ====================
   // Crop table
   // ====================
   always_comb begin
      vcrop = '0;
      wide  = 1'b0;
      if (!scandoubler) begin
         if ({1'b0, hdmi_width} >= min_wide_w) begin
            case (hdmi_height)
               480, 720, 1200: vcrop = `MSX_VCROP_240;
               600, 800: begin
                  vcrop = `MSX_VCROP_200;
                  wide  = vcrop_en;
               end
               768:     vcrop = `MSX_VCROP_256;
               1080:    vcrop = `MSX_VCROP_216;
               default: vcrop = '0;
            endcase
         end else if (hdmi_width >= `MSX_TALL_MIN_W) begin
            // 4:3 panels fall short of the 1.5 ratio test
            case (hdmi_height)
               1440:    vcrop = `MSX_VCROP_240;
               1536:    vcrop = `MSX_VCROP_256;
               default: vcrop = '0;
            endcase
         end
      end
   end

   // ====================
   // Output registers
   // ====================
   always_ff @(posedge clk21m or negedge arst_n) begin
      if (!arst_n) begin
         crop_size <= '0;
         arx       <= '0;
         ary       <= '0;
      end else begin
         crop_size <= vcrop_en ? vcrop : '0;
         if (aspect == msx_glue_pkg::ORIGINAL) begin
            arx <= wide ? `MSX_ARX_WIDE : `MSX_ARX_NARROW;
            ary <= `MSX_ARY_ORIG;
         end else begin
            // Scaler preset index, ary zero selects preset mode
            arx <= AR_W'(aspect) - AR_W'(1);
            ary <= '0;
         end
      end
   end

   a_crop_off: assert property (
      @(posedge clk21m) disable iff (!arst_n) !$past(vcrop_en) |-> (crop_size == '0)
   );

endmodule

// ==== src/msx_glue_params.svh ====
// MSX glue parameters
// Bus widths, SD activity hold time, video crop and aspect constants
`ifndef MSX_GLUE_PARAMS_SVH
`define MSX_GLUE_PARAMS_SVH

`define MSX_HDMI_DIM_W      12
`define MSX_VCROP_W         10
`define MSX_AR_W            12
`define MSX_ASPECT_W        2
`define MSX_DDR_ADDR_W      28
`define MSX_DDR_DATA_W      8

// Activity hold in clk21m cycles
`define MSX_SD_ACT_TIMEOUT  1000000
`define MSX_CAS_INDEX       5

// Vertical crop sizes and the 4:3 panel threshold
`define MSX_VCROP_200       200
`define MSX_VCROP_216       216
`define MSX_VCROP_240       240
`define MSX_VCROP_256       256
`define MSX_TALL_MIN_W      1440

// Aspect numerators for the original ratio
`define MSX_ARX_WIDE        340
`define MSX_ARX_NARROW      400
`define MSX_ARY_ORIG        300

`endif

// ==== src/msx_glue_pkg.sv ====
// MSX glue shared types
// Aspect ratio menu encoding and the DDR3 read client names
`include "msx_glue_params.svh"

package msx_glue_pkg;

   // Menu order of the aspect ratio option
   typedef enum logic [`MSX_ASPECT_W-1:0] {
      ORIGINAL = 2'd0,
      FULL     = 2'd1,
      ARC1     = 2'd2,
      ARC2     = 2'd3
   } aspect_t;

   // Clients of the shared DDR3 byte read port
   typedef enum logic {
      LOADER = 1'b0,
      TAPE   = 1'b1
   } ddr_client_t;

endpackage

// ==== src/msx_glue_top.sv ====
// MSX board glue top level
// Menu status decode, HDMI crop select, SD card routing and the
// shared DDR3 read port, connected at board level
`timescale 1ns/1ps
`include "msx_glue_params.svh"

module msx_glue_top #(
   parameter int ACT_TIMEOUT = `MSX_SD_ACT_TIMEOUT
) (
   input  logic                        clk21m,
   input  logic                        arst_n,
   // OSD and download
   input  logic [63:0]                 status,
   input  logic                        forced_scandoubler,
   input  logic                        board_reset,
   input  logic                        ioctl_download,
   input  logic [15:0]                 ioctl_index,
   output logic [1:0]                  scanlines,
   output msx_glue_pkg::aspect_t       aspect,
   output logic [1:0]                  scale,
   output logic                        vcrop_en,
   output logic                        scandoubler,
   output logic                        sys_reset,
   output logic                        tape_rewind,
   // HDMI
   input  logic [`MSX_HDMI_DIM_W-1:0]  hdmi_width,
   input  logic [`MSX_HDMI_DIM_W-1:0]  hdmi_height,
   output logic [`MSX_VCROP_W-1:0]     crop_size,
   output logic [`MSX_AR_W-1:0]        arx,
   output logic [`MSX_AR_W-1:0]        ary,
   // SD card
   input  logic                        img_mounted,
   input  logic [31:0]                 img_size,
   input  logic                        spi_clk,
   input  logic                        spi_mosi,
   input  logic                        sd_miso,
   input  logic                        vsd_miso,
   output logic                        spi_miso,
   output logic                        sd_cs,
   output logic                        sd_sck,
   output logic                        sd_mosi,
   output logic                        led_user,
   output logic [1:0]                  led_disk,
   // DDR3 clients, LOADER and TAPE
   input  logic                        loader_req,
   input  logic [`MSX_DDR_ADDR_W-1:0]  loader_addr,
   output logic                        loader_ack,
   output logic [`MSX_DDR_DATA_W-1:0]  loader_data,
   input  logic                        tape_req,
   input  logic [`MSX_DDR_ADDR_W-1:0]  tape_addr,
   output logic                        tape_ack,
   output logic [`MSX_DDR_DATA_W-1:0]  tape_data,
   input  logic                        ddr3_ready,
   input  logic [`MSX_DDR_DATA_W-1:0]  ddr3_dout,
   output logic                        ddr3_rd,
   output logic [`MSX_DDR_ADDR_W-1:0]  ddr3_addr
);

   osd_status_decode u_decode (
      .clk21m             (clk21m),
      .arst_n             (arst_n),
      .status             (status),
      .forced_scandoubler (forced_scandoubler),
      .board_reset        (board_reset),
      .ioctl_download     (ioctl_download),
      .ioctl_index        (ioctl_index),
      .scanlines          (scanlines),
      .aspect             (aspect),
      .scale              (scale),
      .vcrop_en           (vcrop_en),
      .scandoubler        (scandoubler),
      .sys_reset          (sys_reset),
      .tape_rewind        (tape_rewind)
   );

   // Decoded fields feed the crop stage, two cycles from status
   hdmi_crop_select u_crop (
      .clk21m      (clk21m),
      .arst_n      (arst_n),
      .hdmi_width  (hdmi_width),
      .hdmi_height (hdmi_height),
      .scandoubler (scandoubler),
      .vcrop_en    (vcrop_en),
      .aspect      (aspect),
      .crop_size   (crop_size),
      .arx         (arx),
      .ary         (ary)
   );

   sd_card_select #(
      .ACT_TIMEOUT (ACT_TIMEOUT)
   ) u_sd (
      .clk21m      (clk21m),
      .arst_n      (arst_n),
      .img_mounted (img_mounted),
      .img_size    (img_size),
      .spi_clk     (spi_clk),
      .spi_mosi    (spi_mosi),
      .sd_miso     (sd_miso),
      .vsd_miso    (vsd_miso),
      .spi_miso    (spi_miso),
      .sd_cs       (sd_cs),
      .sd_sck      (sd_sck),
      .sd_mosi     (sd_mosi),
      .led_user    (led_user),
      .led_disk    (led_disk)
   );

   ddr3_read_arbiter u_arb (
      .clk21m      (clk21m),
      .arst_n      (arst_n),
      .loader_req  (loader_req),
      .loader_addr (loader_addr),
      .loader_ack  (loader_ack),
      .loader_data (loader_data),
      .tape_req    (tape_req),
      .tape_addr   (tape_addr),
      .tape_ack    (tape_ack),
      .tape_data   (tape_data),
      .ddr3_ready  (ddr3_ready),
      .ddr3_dout   (ddr3_dout),
      .ddr3_rd     (ddr3_rd),
      .ddr3_addr   (ddr3_addr)
   );

endmodule

// ==== src/osd_status_decode.sv ====
// OSD status decode
// Registers the menu fields of the 64-bit status word and derives the
// scandoubler, system reset and tape rewind requests
`timescale 1ns/1ps
`include "msx_glue_params.svh"

module osd_status_decode (
   input  logic                  clk21m,
   input  logic                  arst_n,
   input  logic [63:0]           status,
   input  logic                  forced_scandoubler,
   input  logic                  board_reset,
   input  logic                  ioctl_download,
   input  logic [15:0]           ioctl_index,
   output logic [1:0]            scanlines,
   output msx_glue_pkg::aspect_t aspect,
   output logic [1:0]            scale,
   output logic                  vcrop_en,
   output logic                  scandoubler,
   output logic                  sys_reset,
   output logic                  tape_rewind
);

   logic cas_load;
   logic reset_req;

   // A CAS file download restarts the tape
   assign cas_load  = ioctl_download && (ioctl_index[5:0] == 6'(`MSX_CAS_INDEX));
   // Board reset, menu reset, reset and detach
   assign reset_req = board_reset | status[0] | status[10];

   always_ff @(posedge clk21m or negedge arst_n) begin
      if (!arst_n) begin
         scanlines   <= '0;
         aspect      <= msx_glue_pkg::ORIGINAL;
         scale       <= '0;
         vcrop_en    <= 1'b0;
         scandoubler <= 1'b0;
         sys_reset   <= 1'b0;
         tape_rewind <= 1'b0;
      end else begin
         scanlines   <= status[4:3];
         aspect      <= msx_glue_pkg::aspect_t'(status[2:1]);
         scale       <= status[6:5];
         vcrop_en    <= status[7];
         scandoubler <= forced_scandoubler | (|status[4:3]);
         sys_reset   <= reset_req;
         // Reset term taken from the raw inputs to keep the same latency
         tape_rewind <= status[9] | cas_load | reset_req;
      end
   end

   // Any system reset must also rewind the tape
   a_reset_rewinds: assert property (
      @(posedge clk21m) disable iff (!arst_n) sys_reset |-> tape_rewind
   );

endmodule

// ==== src/sd_card_select.sv ====
// SD card select
// Switches SPI between the physical card and the virtual card image
// and holds the disk activity LEDs for a while after traffic
`timescale 1ns/1ps
`include "msx_glue_params.svh"

module sd_card_select #(
   parameter int ACT_TIMEOUT = `MSX_SD_ACT_TIMEOUT
) (
   input  logic        clk21m,
   input  logic        arst_n,
   input  logic        img_mounted,
   input  logic [31:0] img_size,
   input  logic        spi_clk,
   input  logic        spi_mosi,
   input  logic        sd_miso,
   input  logic        vsd_miso,
   output logic        spi_miso,
   output logic        sd_cs,
   output logic        sd_sck,
   output logic        sd_mosi,
   output logic        led_user,
   output logic [1:0]  led_disk
);

   localparam int CNT_W = $clog2(ACT_TIMEOUT + 1);

   logic             vsd_sel;
   logic             mosi_q;
   logic             miso_q;
   logic [CNT_W-1:0] act_cnt;
   logic             sd_act;

   // Virtual card used when a nonempty image is mounted
   always_ff @(posedge clk21m or negedge arst_n) begin
      if (!arst_n) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted) begin
         vsd_sel <= |img_size;
      end
   end

   assign spi_miso = vsd_sel ? vsd_miso : sd_miso;
   // Physical card deselected and quiet while the image is in use
   assign sd_cs    = vsd_sel;
   assign sd_sck   = spi_clk & ~vsd_sel;
   assign sd_mosi  = spi_mosi & ~vsd_sel;

   // ====================
   // Activity timeout
   // ====================
   always_ff @(posedge clk21m) begin
      mosi_q <= spi_mosi;
      miso_q <= spi_miso;
   end

   // Starts expired so the LEDs stay dark out of reset
   always_ff @(posedge clk21m or negedge arst_n) begin
      if (!arst_n) begin
         act_cnt <= CNT_W'(ACT_TIMEOUT);
         sd_act  <= 1'b0;
      end else begin
         sd_act <= (act_cnt < CNT_W'(ACT_TIMEOUT));
         if ((mosi_q ^ spi_mosi) || (miso_q ^ spi_miso)) begin
            act_cnt <= '0;
         end else if (act_cnt < CNT_W'(ACT_TIMEOUT)) begin
            act_cnt <= act_cnt + 1'b1;
         end
      end
   end

   assign led_user = vsd_sel & sd_act;
   // Bit 1 gives the core sole control of the disk LED
   assign led_disk = {1'b1, ~vsd_sel & sd_act};

   a_sck_idle: assert property (
      @(posedge clk21m) disable iff (!arst_n) sd_cs |-> !sd_sck
   );

endmodule

// ==== test/tb_msx_glue.sv ====
// MSX glue testbench
// Random stimulus from an xorshift generator checked against models of
// the status decode, crop table, SD routing, activity LEDs and DDR3 reads
`timescale 1ns/1ps
`include "msx_glue_params.svh"

module tb_msx_glue;

   localparam int ACT_CYCLES     = 20;
   localparam int TIMEOUT_CYCLES = 20000;

   logic                        clk21m;
   logic                        arst_n;
   logic [63:0]                 status;
   logic                        forced_scandoubler;
   logic                        board_reset;
   logic                        ioctl_download;
   logic [15:0]                 ioctl_index;
   logic [1:0]                  scanlines;
   msx_glue_pkg::aspect_t       aspect;
   logic [1:0]                  scale;
   logic                        vcrop_en;
   logic                        scandoubler;
   logic                        sys_reset;
   logic                        tape_rewind;
   logic [`MSX_HDMI_DIM_W-1:0]  hdmi_width;
   logic [`MSX_HDMI_DIM_W-1:0]  hdmi_height;
   logic [`MSX_VCROP_W-1:0]     crop_size;
   logic [`MSX_AR_W-1:0]        arx;
   logic [`MSX_AR_W-1:0]        ary;
   logic                        img_mounted;
   logic [31:0]                 img_size;
   logic                        spi_clk;
   logic                        spi_mosi;
   logic                        sd_miso;
   logic                        vsd_miso;
   logic                        spi_miso;
   logic                        sd_cs;
   logic                        sd_sck;
   logic                        sd_mosi;
   logic                        led_user;
   logic [1:0]                  led_disk;
   logic                        loader_req;
   logic [`MSX_DDR_ADDR_W-1:0]  loader_addr;
   logic                        loader_ack;
   logic [`MSX_DDR_DATA_W-1:0]  loader_data;
   logic                        tape_req;
   logic [`MSX_DDR_ADDR_W-1:0]  tape_addr;
   logic                        tape_ack;
   logic [`MSX_DDR_DATA_W-1:0]  tape_data;
   logic                        ddr3_ready;
   logic [`MSX_DDR_DATA_W-1:0]  ddr3_dout;
   logic                        ddr3_rd;
   logic [`MSX_DDR_ADDR_W-1:0]  ddr3_addr;

   logic [31:0]                 rng;
   logic [31:0]                 ddr_rng;
   int                          ddr_wait;
   logic [`MSX_DDR_ADDR_W-1:0]  ddr_addr_q;
   int                          cycle_count;
   int                          heights [9] = '{480, 720, 1200, 600, 800, 768, 1080, 1440, 1536};

   msx_glue_top #(
      .ACT_TIMEOUT (ACT_CYCLES)
   ) DUT (.*);

   always #2 clk21m = ~clk21m;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] rand_word();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // Expected crop from the output resolution table
   function automatic logic [9:0] crop_model(input logic [11:0] w, input logic [11:0] h,
                                             input logic sd, input logic ven);
      logic [9:0] c;
      c = '0;
      if (!sd) begin
         if (int'(w) >= int'(h) + int'(h) / 2) begin
            case (h)
               480, 720, 1200: c = 10'd240;
               600, 800:       c = 10'd200;
               768:            c = 10'd256;
               1080:           c = 10'd216;
               default:        c = '0;
            endcase
         end else if (w >= 12'd1440) begin
            if (h == 12'd1440) begin
               c = 10'd240;
            end else if (h == 12'd1536) begin
               c = 10'd256;
            end
         end
      end
      return ven ? c : 10'd0;
   endfunction

   function automatic logic wide_model(input logic [11:0] w, input logic [11:0] h,
                                       input logic sd, input logic ven);
      return !sd && (int'(w) >= int'(h) + int'(h) / 2) && (h == 12'd600 || h == 12'd800) && ven;
   endfunction

   task automatic step(input int n);
      repeat (n) begin
         @(posedge clk21m);
         #1;
      end
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
      if (got !== expected) begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
         $display("TESTS FAILED");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic mount_image(input logic [31:0] size);
      img_size    = size;
      img_mounted = 1'b1;
      step(1);
      img_mounted = 1'b0;
      img_size    = rand_word();
      check_value("sd_cs", sd_cs, size != 0);
   endtask

   // DDR3 byte read port with ready 1 to 6 cycles after rd
   always @(posedge clk21m) begin
      #1;
      ddr3_ready = 1'b0;
      if (ddr3_rd) begin
         ddr_rng    = xorshift32(ddr_rng);
         ddr_wait   = 1 + int'(ddr_rng % 6);
         ddr_addr_q = ddr3_addr;
      end else if (ddr_wait > 0) begin
         ddr_wait = ddr_wait - 1;
         if (ddr_wait == 0) begin
            ddr3_ready = 1'b1;
            ddr3_dout  = ddr_addr_q[7:0] ^ 8'h5A;
         end
      end
   end

   always @(posedge clk21m) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TESTS FAILED");
         $fatal(1, "Simulation timeout");
      end
   end

   initial begin
      logic [31:0] r;
      logic [31:0] r2;
      logic [63:0] st;
      logic [11:0] w;
      logic [11:0] h;
      logic        exp_reset;
      logic        exp_cas;
      logic        wide;
      logic        act;
      logic        sel;
      logic        both;
      logic        loader_done;
      clk21m = 1'b0;
      arst_n = 1'b0;
      rng = 32'd6;
      ddr_rng = 32'd6;
      ddr_wait = 0;
      cycle_count = 0;
      status = '0;
      forced_scandoubler = 1'b0;
      board_reset = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index = '0;
      hdmi_width = '0;
      hdmi_height = '0;
      img_mounted = 1'b0;
      img_size = '0;
      spi_clk = 1'b0;
      spi_mosi = 1'b0;
      sd_miso = 1'b0;
      vsd_miso = 1'b0;
      loader_req = 1'b0;
      loader_addr = '0;
      tape_req = 1'b0;
      tape_addr = '0;
      ddr3_ready = 1'b0;
      ddr3_dout = '0;
      repeat (4) @(posedge clk21m);
      #1;
      arst_n = 1'b1;

      // Reset values
      check_value("led_user", led_user, 1'b0);
      check_value("led_disk", led_disk, 2'b10);
      check_value("ddr3_rd", ddr3_rd, 1'b0);
      check_value("loader_ack", loader_ack, 1'b0);
      check_value("tape_ack", tape_ack, 1'b0);
      check_value("loader_data", loader_data, 8'h00);
      check_value("tape_data", tape_data, 8'h00);

      // ====================
      // Status decode
      // ====================
      for (int i = 0; i < 200; i++) begin
         r = rand_word();
         st = {rand_word(), rand_word()};
         if (r[0]) begin
            st[0] = 1'b0;
            st[10] = 1'b0;
         end
         status = st;
         forced_scandoubler = r[1];
         board_reset = (r[3:2] == 2'b00);
         ioctl_download = r[4];
         ioctl_index = r[5] ? {r[31:22], 6'd5} : r[31:16];
         step(2);
         exp_reset = board_reset | st[0] | st[10];
         exp_cas = ioctl_download && (ioctl_index[5:0] == 6'd5);
         check_value("scanlines", scanlines, st[4:3]);
         check_value("aspect", aspect, st[2:1]);
         check_value("scale", scale, st[6:5]);
         check_value("vcrop_en", vcrop_en, st[7]);
         check_value("scandoubler", scandoubler, forced_scandoubler | (|st[4:3]));
         check_value("sys_reset", sys_reset, exp_reset);
         check_value("tape_rewind", tape_rewind, st[9] | exp_cas | exp_reset);
      end
      board_reset = 1'b0;
      ioctl_download = 1'b0;

      // ====================
      // Crop table and aspect
      // ====================
      for (int hi = 0; hi < 9; hi++) begin
         for (int wi = 0; wi < 4; wi++) begin
            h = 12'(heights[hi]);
            r = rand_word();
            // Exactly on and just below the 1.5 ratio and then random widths
            w = (wi < 2) ? 12'(int'(h) + int'(h) / 2 - wi) : r[11:0];
            for (int m = 0; m < 4; m++) begin
               status = '0;
               status[7] = m[0];
               forced_scandoubler = m[1];
               hdmi_width = w;
               hdmi_height = h;
               step(2);
               check_value("crop_size", crop_size, crop_model(w, h, m[1], m[0]));
            end
         end
      end
      forced_scandoubler = 1'b0;
      for (int a = 0; a < 4; a++) begin
         for (int ws = 0; ws < 2; ws++) begin
            h = ws ? 12'd600 : 12'd480;
            status = '0;
            status[7] = 1'b1;
            status[2:1] = 2'(a);
            hdmi_width = 12'd1920;
            hdmi_height = h;
            step(2);
            wide = wide_model(12'd1920, h, 1'b0, 1'b1);
            check_value("arx", arx, (a == 0) ? (wide ? 340 : 400) : a - 1);
            check_value("ary", ary, (a == 0) ? 300 : 0);
         end
      end

      // ====================
      // SD routing and activity
      // ====================
      for (int p = 0; p < 3; p++) begin
         r2 = rand_word() | 32'd1;
         mount_image((p == 1) ? 32'd0 : r2);
         sel = (p != 1);
         repeat (16) begin
            r = rand_word();
            spi_clk = r[0];
            spi_mosi = r[1];
            sd_miso = r[2];
            vsd_miso = r[3];
            #1;
            check_value("sd_sck", sd_sck, r[0] & !sel);
            check_value("sd_mosi", sd_mosi, r[1] & !sel);
            check_value("spi_miso", spi_miso, sel ? r[3] : r[2]);
            step(1);
         end
      end
      for (int p = 0; p < 2; p++) begin
         spi_clk = 1'b0;
         spi_mosi = 1'b0;
         sd_miso = 1'b0;
         vsd_miso = 1'b0;
         mount_image(p ? 32'h0000_1000 : 32'd0);
         step(ACT_CYCLES + 4);
         check_value("led_user", led_user, 1'b0);
         check_value("led_disk", led_disk, 2'b10);
         spi_mosi = 1'b1;
         for (int k = 1; k <= ACT_CYCLES + 3; k++) begin
            step(1);
            // Counter clears one cycle after the edge and the LED follows a cycle later
            if (k >= 2) begin
               act = (k <= ACT_CYCLES + 1);
               check_value("led_user", led_user, p[0] & act);
               check_value("led_disk", led_disk, {1'b1, !p[0] & act});
            end
         end
      end

      // ====================
      // DDR3 arbitration
      // ====================
      for (int i = 0; i < 150; i++) begin
         r = rand_word();
         r2 = rand_word();
         loader_addr = r2[27:0];
         r2 = rand_word();
         tape_addr = r2[27:0];
         loader_req = (r[1:0] != 2'd1);
         tape_req = (r[1:0] != 2'd0);
         both = loader_req && tape_req;
         loader_done = 1'b0;
         while (loader_req || tape_req || loader_ack || tape_ack) begin
            step(1);
            if (loader_ack && loader_req) begin
               check_value("ddr3_addr", ddr_addr_q, loader_addr);
               check_value("loader_data", loader_data, loader_addr[7:0] ^ 8'h5A);
               loader_req = 1'b0;
               loader_done = 1'b1;
            end
            if (tape_ack && tape_req) begin
               check_value("ddr3_addr", ddr_addr_q, tape_addr);
               check_value("tape_data", tape_data, tape_addr[7:0] ^ 8'h5A);
               if (both) begin
                  check_value("loader_ack before tape_ack", loader_done, 1'b1);
               end
               tape_req = 1'b0;
            end
         end
         step(int'(r[3:2]));
      end

      $display("TESTS PASSED");
      $finish;
   end

endmodule
